// File: verilog.f
rtl/bs_pkg.sv
rtl/dispatch_ctrl.sv
rtl/branch_stack.sv
rtl/rename_map.sv
rtl/branch_recovery_top.sv
tests/tb_clock_gen.sv
tests/branch_recovery_chk.sv
tests/branch_recovery_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := branch_recovery_tb
RTL_TOP    := branch_recovery_top
FILELIST   := verilog.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation of $(RTL_TOP) failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/branch_recovery_tb.sv
`timescale 1ns/1ps

module branch_recovery_tb;

    import bs_pkg::*;

    localparam int RAND_SEED  = 27;
    localparam int RAND_STEPS = 80;
    localparam int WAIT_LIMIT = 20;

    // One row of stimulus with the expected strobes
    typedef struct {
        logic      dv, br, hd;
        arch_idx_t dest;
        logic      cv;
        b_mask_t   slot;
        logic      mis, tkn;
        addr_t     target;
        logic      e_stall, e_fire, e_restore;
    } step_t;

    logic       clock;
    logic       reset;
    logic       dispatch_valid, dispatch_branch, dispatch_has_dest;
    arch_idx_t  dispatch_dest;
    rob_idx_t   dispatch_rob_tail;
    addr_t      dispatch_fallthrough_pc;
    logic       complete_valid, complete_mispred, complete_taken;
    b_mask_t    complete_slot;
    addr_t      complete_target;
    arch_idx_t  lookup_arch;
    logic       dispatch_stall, dispatch_fire, restore_valid;
    b_mask_t    dispatch_tag, resolved_mask, live_mask;
    phys_idx_t  dispatch_phys, lookup_phys;
    addr_t      pc_restore;
    rob_idx_t   rob_tail_restore;
    logic [4:0] free_count;

    // Reference model of map, free vector, live slots and checkpoints
    map_vec_t  m_map;
    free_vec_t m_free;
    b_mask_t   m_live;
    b_mask_t   cp_dep [B_MASK_WIDTH];
    rob_idx_t  cp_tail [B_MASK_WIDTH];
    addr_t     cp_pc [B_MASK_WIDTH];
    map_vec_t  cp_map [B_MASK_WIDTH];
    free_vec_t cp_free [B_MASK_WIDTH];
    step_t     rows [$];
    int        step_no;
    int        checks;
    int        errors;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    branch_recovery_top u_branch_recovery_top (.*);

    function automatic phys_idx_t lowest_free(free_vec_t f);
        for (int i = 0; i < PHYS_REGS; i++) begin
            if (f[i]) begin
                return phys_idx_t'(i);
            end
        end
        return '0;
    endfunction

    function automatic b_mask_t lowest_clear(b_mask_t m);
        for (int i = 0; i < B_MASK_WIDTH; i++) begin
            if (!m[i]) begin
                return b_mask_t'(1) << i;
            end
        end
        return '0;
    endfunction

    function automatic int slot_index(b_mask_t oh);
        for (int i = 0; i < B_MASK_WIDTH; i++) begin
            if (oh[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    // One-hot random live slot or zero when none is live
    function automatic b_mask_t pick_live();
        int first;
        first = $urandom_range(0, B_MASK_WIDTH - 1);
        for (int n = 0; n < B_MASK_WIDTH; n++) begin
            if (m_live[(first + n) % B_MASK_WIDTH]) begin
                return b_mask_t'(1) << ((first + n) % B_MASK_WIDTH);
            end
        end
        return '0;
    endfunction

    // Fill in the strobes the model expects for this row
    function automatic step_t predict(step_t s);
        step_t p;
        p = s;
        p.e_restore = s.cv && (|(s.slot & m_live)) && s.mis;
        p.e_stall   = s.dv && ((s.br && (&m_live)) || (s.hd && (m_free == '0)));
        p.e_fire    = s.dv && !p.e_stall && !p.e_restore;
        return p;
    endfunction

    function automatic step_t random_step();
        step_t s;
        s = '{default: '0};
        s.dv     = ($urandom_range(0, 2) != 0);
        s.br     = ($urandom_range(0, 2) == 0);
        // Renames only while a register is free since no retirement returns one
        s.hd     = !s.br && (m_free != '0) && ($urandom_range(0, 3) != 0);
        s.dest   = arch_idx_t'($urandom_range(0, ARCH_REGS - 1));
        s.cv     = ($urandom_range(0, 2) == 0);
        s.slot   = b_mask_t'(1) << $urandom_range(0, B_MASK_WIDTH - 1);
        s.mis    = ($urandom_range(0, 3) == 0);
        s.tkn    = ($urandom_range(0, 1) == 1);
        s.target = addr_t'($urandom());
        return s;
    endfunction

    task automatic add_row(input logic dv, br, hd, input arch_idx_t dest, input logic cv,
                           input b_mask_t slot, input logic mis, tkn, input addr_t target,
                           input logic es, ef, er);
        rows.push_back('{dv, br, hd, dest, cv, slot, mis, tkn, target, es, ef, er});
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Strobes stay low while reset holds, whatever the inputs do
    task automatic expect_quiet_in_reset();
        check("dispatch_fire", 32'(dispatch_fire), 32'(0));
        check("restore_valid", 32'(restore_valid), 32'(0));
        check("resolved_mask", 32'(resolved_mask), 32'(0));
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // Drive on the falling edge, check before the rising edge, then step the model
    task automatic run_step(input step_t s, output logic fired);
        b_mask_t  e_res;
        b_mask_t  freed;
        b_mask_t  new_oh;
        rob_idx_t tail;
        addr_t    ft_pc;
        int       k;
        tail  = rob_idx_t'(step_no);
        ft_pc = addr_t'(32'h1000 + 4 * step_no);
        @(negedge clock);
        dispatch_valid          = s.dv;
        dispatch_branch         = s.br;
        dispatch_has_dest       = s.hd;
        dispatch_dest           = s.dest;
        dispatch_rob_tail       = tail;
        dispatch_fallthrough_pc = ft_pc;
        complete_valid          = s.cv;
        complete_slot           = s.slot;
        complete_mispred        = s.mis;
        complete_taken          = s.tkn;
        complete_target         = s.target;
        lookup_arch             = arch_idx_t'(step_no);
        #10;
        e_res = s.cv ? (s.slot & m_live) : '0;
        k     = slot_index(e_res);
        check("dispatch_stall", 32'(dispatch_stall), 32'(s.e_stall));
        check("dispatch_fire", 32'(dispatch_fire), 32'(s.e_fire));
        check("restore_valid", 32'(restore_valid), 32'(s.e_restore));
        check("resolved_mask", 32'(resolved_mask), 32'(e_res));
        check("live_mask", 32'(live_mask), 32'(m_live));
        check("dispatch_tag", 32'(dispatch_tag), 32'(m_live));
        check("free_count", 32'(free_count), 32'($countones(m_free)));
        check("lookup_phys", 32'(lookup_phys),
              32'(m_map[int'(lookup_arch)*PHYS_IDX_WIDTH +: PHYS_IDX_WIDTH]));
        if (s.e_fire && s.hd) begin
            check("dispatch_phys", 32'(dispatch_phys), 32'(lowest_free(m_free)));
        end
        if (s.e_restore) begin
            check("pc_restore", pc_restore, s.tkn ? s.target : cp_pc[k]);
            check("rob_tail_restore", 32'(rob_tail_restore), 32'(cp_tail[k]));
        end
        fired = dispatch_fire;
        @(posedge clock);
        freed = e_res;
        if (s.e_restore) begin
            m_map  = cp_map[k];
            m_free = cp_free[k];
            for (int j = 0; j < B_MASK_WIDTH; j++) begin
                freed[j] = freed[j] | (|(cp_dep[j] & e_res));
            end
        end
        for (int j = 0; j < B_MASK_WIDTH; j++) begin
            cp_dep[j] = freed[j] ? '0 : (cp_dep[j] & ~e_res);
        end
        new_oh = (s.e_fire && s.br) ? lowest_clear(m_live) : '0;
        if (new_oh != '0) begin
            k          = slot_index(new_oh);
            cp_dep[k]  = m_live & ~freed;
            cp_tail[k] = tail;
            cp_pc[k]   = ft_pc;
            cp_map[k]  = m_map;
            cp_free[k] = m_free;
        end
        if (s.e_fire && s.hd) begin
            m_map[int'(s.dest)*PHYS_IDX_WIDTH +: PHYS_IDX_WIDTH] = lowest_free(m_free);
            m_free[lowest_free(m_free)] = 1'b0;
        end
        m_live = (m_live & ~freed) | new_oh;
        step_no++;
    endtask

    initial begin
        step_t s;
        logic  fired;
        int    waited;
        void'($urandom(RAND_SEED));
        // Active dispatch and mispredict strobes while reset holds
        dispatch_valid          = 1'b1;
        dispatch_branch         = 1'b0;
        dispatch_has_dest       = 1'b1;
        dispatch_dest           = '0;
        dispatch_rob_tail       = '0;
        dispatch_fallthrough_pc = '0;
        complete_valid          = 1'b1;
        complete_slot           = 4'h1;
        complete_mispred        = 1'b1;
        complete_taken          = 1'b0;
        complete_target         = '0;
        lookup_arch             = '0;
        step_no = 0;
        checks  = 0;
        errors  = 0;
        m_map   = RESET_MAP;
        m_free  = RESET_FREE;
        m_live  = '0;
        for (int j = 0; j < B_MASK_WIDTH; j++) begin
            cp_dep[j]  = '0;
            cp_tail[j] = '0;
            cp_pc[j]   = '0;
            cp_map[j]  = '0;
            cp_free[j] = '0;
        end

        // dv br hd dest | cv slot mis tkn target | stall fire restore
        add_row(1'b1, 1'b0, 1'b1, 3'd1, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        add_row(1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        add_row(1'b1, 1'b0, 1'b1, 3'd2, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        add_row(1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        add_row(1'b1, 1'b0, 1'b1, 3'd3, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        add_row(1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        add_row(1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        // Fifth branch finds every slot taken
        add_row(1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, 1'b0, 3'd0, 1'b1, 4'h2, 1'b0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        // Oldest branch taken and mispredicted while a rename waits
        add_row(1'b1, 1'b0, 1'b1, 3'd4, 1'b1, 4'h1, 1'b1, 1'b1, 32'h2000, 1'b0, 1'b0, 1'b1);
        add_row(1'b0, 1'b0, 1'b0, 3'd0, 1'b1, 4'h4, 1'b1, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 1'b1, 1'b0, 3'd0, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        for (int a = 0; a < 7; a++) begin
            add_row(1'b1, 1'b0, 1'b1, arch_idx_t'(a), 1'b0, 4'h0, 1'b0, 1'b0, 32'h0,
                    1'b0, 1'b1, 1'b0);
        end
        add_row(1'b1, 1'b0, 1'b1, 3'd7, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b1, 1'b0, 1'b0);
        add_row(1'b1, 1'b0, 1'b1, 3'd7, 1'b1, 4'h1, 1'b1, 1'b0, 32'hdead0000, 1'b1, 1'b0, 1'b1);
        add_row(1'b1, 1'b0, 1'b1, 3'd7, 1'b0, 4'h0, 1'b0, 1'b0, 32'h0, 1'b0, 1'b1, 1'b0);

        // Once before the first edge and once with the state already reset
        #10;
        expect_quiet_in_reset();
        @(negedge clock);
        expect_quiet_in_reset();
        dispatch_valid    = 1'b0;
        dispatch_has_dest = 1'b0;
        complete_valid    = 1'b0;
        complete_slot     = '0;
        complete_mispred  = 1'b0;

        waited = 0;
        while (reset !== 1'b0 && waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end

        if (reset !== 1'b0) begin
            errors++;
            $display("Timeout: reset never released");
        end else begin
            // Idle steps walk lookup_arch over every architectural register
            s = '{default: '0};
            for (int i = 0; i < ARCH_REGS; i++) begin
                run_step(s, fired);
            end
            foreach (rows[i]) begin
                run_step(rows[i], fired);
            end

            for (int n = 0; n < RAND_STEPS; n++) begin
                s = random_step();
                run_step(predict(s), fired);
                waited = 0;
                while (s.dv && !fired && waited < WAIT_LIMIT) begin
                    // Resolve a live branch correctly so a slot opens up
                    s.slot = pick_live();
                    s.cv   = (s.slot != '0);
                    s.mis  = 1'b0;
                    run_step(predict(s), fired);
                    waited++;
                end
                if (s.dv && !fired) begin
                    errors++;
                    $display("Timeout: held dispatch was never accepted");
                    break;
                end
            end
        end
        finish_run();
    end

endmodule

// File: tests/branch_recovery_chk.sv
`timescale 1ns/1ps

module branch_recovery_chk (
    input logic            clock,
    input logic            reset,
    input logic            dispatch_fire,
    input logic            restore_valid,
    input bs_pkg::b_mask_t resolved_mask,
    input bs_pkg::b_mask_t live_mask,
    input logic [4:0]      free_count
);

    // A restore always comes from a single resolving slot
    restore_one_slot: assert property (@(posedge clock) disable iff (reset)
        restore_valid |-> $onehot(resolved_mask))
        else $error("restore_valid with resolved_mask %b", resolved_mask);

    fire_not_on_restore: assert property (@(posedge clock) disable iff (reset)
        !(dispatch_fire && restore_valid))
        else $error("dispatch fired in a restore cycle");

    // Resolved slots leave the live mask at the next edge
    resolved_leaves_live: assert property (@(posedge clock) disable iff (reset)
        (resolved_mask != '0) |=> ((live_mask & $past(resolved_mask)) == '0))
        else $error("resolved slot still live, live_mask %b", live_mask);

    // Physical registers only come back through a restore
    free_count_no_rise: assert property (@(posedge clock) disable iff (reset)
        !$past(restore_valid) |-> (free_count <= $past(free_count)))
        else $error("free_count rose to %0d without a restore", free_count);

endmodule

bind branch_recovery_top branch_recovery_chk u_branch_recovery_chk (.*);

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    localparam time HALF_PERIOD = 20ns;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // Reset spans the first 10 rising edges and drops on a falling edge
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

// File: rtl/branch_recovery_top.sv
`timescale 1ns/1ps

module branch_recovery_top (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  logic              dispatch_branch,
    input  logic              dispatch_has_dest,
    input  bs_pkg::arch_idx_t dispatch_dest,
    input  bs_pkg::rob_idx_t  dispatch_rob_tail,
    input  bs_pkg::addr_t     dispatch_fallthrough_pc,
    input  logic              complete_valid,
    input  bs_pkg::b_mask_t   complete_slot,
    input  logic              complete_mispred,
    input  logic              complete_taken,
    input  bs_pkg::addr_t     complete_target,
    input  bs_pkg::arch_idx_t lookup_arch,
    output logic              dispatch_stall,
    output logic              dispatch_fire,
    output bs_pkg::b_mask_t   dispatch_tag,
    output bs_pkg::phys_idx_t dispatch_phys,
    output logic              restore_valid,
    output bs_pkg::addr_t     pc_restore,
    output bs_pkg::rob_idx_t  rob_tail_restore,
    output bs_pkg::b_mask_t   resolved_mask,
    output bs_pkg::b_mask_t   live_mask,
    output bs_pkg::phys_idx_t lookup_phys,
    output logic [4:0]        free_count
);

    import bs_pkg::*;

    b_mask_t   new_slot;
    b_mask_t   surviving_mask;
    map_vec_t  restore_map;
    free_vec_t restore_free;
    map_vec_t  map_snapshot;
    free_vec_t free_snapshot;
    logic      free_empty;

    // Every dispatched instruction depends on all branches still live
    assign dispatch_tag = live_mask;

    dispatch_ctrl u_dispatch_ctrl (
        .clock             (clock),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .dispatch_branch   (dispatch_branch),
        .dispatch_has_dest (dispatch_has_dest),
        .free_empty        (free_empty),
        .restore_valid     (restore_valid),
        .surviving_mask    (surviving_mask),
        .live_mask         (live_mask),
        .new_slot          (new_slot),
        .dispatch_stall    (dispatch_stall),
        .dispatch_fire     (dispatch_fire)
    );

    branch_stack u_branch_stack (
        .clock                   (clock),
        .reset                   (reset),
        .dispatch_fire           (dispatch_fire),
        .live_mask               (live_mask),
        .new_slot                (new_slot),
        .dispatch_rob_tail       (dispatch_rob_tail),
        .dispatch_fallthrough_pc (dispatch_fallthrough_pc),
        .map_snapshot            (map_snapshot),
        .free_snapshot           (free_snapshot),
        .complete_valid          (complete_valid),
        .complete_slot           (complete_slot),
        .complete_mispred        (complete_mispred),
        .complete_taken          (complete_taken),
        .complete_target         (complete_target),
        .restore_valid           (restore_valid),
        .pc_restore              (pc_restore),
        .rob_tail_restore        (rob_tail_restore),
        .restore_map             (restore_map),
        .restore_free            (restore_free),
        .resolved_mask           (resolved_mask),
        .surviving_mask          (surviving_mask)
    );

    rename_map u_rename_map (
        .clock             (clock),
        .reset             (reset),
        .dispatch_fire     (dispatch_fire),
        .dispatch_has_dest (dispatch_has_dest),
        .dispatch_dest     (dispatch_dest),
        .restore_valid     (restore_valid),
        .restore_map       (restore_map),
        .restore_free      (restore_free),
        .lookup_arch       (lookup_arch),
        .dispatch_phys     (dispatch_phys),
        .lookup_phys       (lookup_phys),
        .free_empty        (free_empty),
        .map_snapshot      (map_snapshot),
        .free_snapshot     (free_snapshot),
        .free_count        (free_count)
    );

endmodule

// File: rtl/rename_map.sv
`timescale 1ns/1ps

module rename_map (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_fire,
    input  logic              dispatch_has_dest,
    input  bs_pkg::arch_idx_t dispatch_dest,
    input  logic              restore_valid,
    input  bs_pkg::map_vec_t  restore_map,
    input  bs_pkg::free_vec_t restore_free,
    input  bs_pkg::arch_idx_t lookup_arch,
    output bs_pkg::phys_idx_t dispatch_phys,
    output bs_pkg::phys_idx_t lookup_phys,
    output logic              free_empty,
    output bs_pkg::map_vec_t  map_snapshot,
    output bs_pkg::free_vec_t free_snapshot,
    output logic [4:0]        free_count
);

    import bs_pkg::*;

    map_vec_t  map_q;
    free_vec_t free_q;
    phys_idx_t alloc_idx;
    logic      rename_en;

    // Lowest free physical register
    always_comb begin
        alloc_idx = '0;
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                alloc_idx = phys_idx_t'(i);
            end
        end
    end

    assign free_empty    = ~|free_q;
    assign dispatch_phys = alloc_idx;
    assign rename_en     = dispatch_fire && dispatch_has_dest;

    assign lookup_phys = map_q[int'(lookup_arch)*PHYS_IDX_WIDTH +: PHYS_IDX_WIDTH];

    // Branch stack captures the state as it is before the branch
    assign map_snapshot  = map_q;
    assign free_snapshot = free_q;

    always_comb begin
        free_count = '0;
        for (int i = 0; i < PHYS_REGS; i++) begin
            free_count = free_count + 5'(free_q[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            map_q  <= RESET_MAP;
            free_q <= RESET_FREE;
        end else if (restore_valid) begin
            map_q  <= restore_map;
            free_q <= restore_free;
        end else if (rename_en) begin
            map_q[int'(dispatch_dest)*PHYS_IDX_WIDTH +: PHYS_IDX_WIDTH] <= alloc_idx;
            free_q[alloc_idx] <= 1'b0;
        end
    end

endmodule

// File: rtl/branch_stack.sv
`timescale 1ns/1ps

module branch_stack (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_fire,
    input  bs_pkg::b_mask_t   live_mask,
    input  bs_pkg::b_mask_t   new_slot,
    input  bs_pkg::rob_idx_t  dispatch_rob_tail,
    input  bs_pkg::addr_t     dispatch_fallthrough_pc,
    input  bs_pkg::map_vec_t  map_snapshot,
    input  bs_pkg::free_vec_t free_snapshot,
    input  logic              complete_valid,
    input  bs_pkg::b_mask_t   complete_slot,
    input  logic              complete_mispred,
    input  logic              complete_taken,
    input  bs_pkg::addr_t     complete_target,
    output logic              restore_valid,
    output bs_pkg::addr_t     pc_restore,
    output bs_pkg::rob_idx_t  rob_tail_restore,
    output bs_pkg::map_vec_t  restore_map,
    output bs_pkg::free_vec_t restore_free,
    output bs_pkg::b_mask_t   resolved_mask,
    output bs_pkg::b_mask_t   surviving_mask
);

    import bs_pkg::*;

    // One checkpoint per branch slot
    b_mask_t   dep_mask [B_MASK_WIDTH];
    rob_idx_t  cp_rob_tail [B_MASK_WIDTH];
    addr_t     cp_fallthrough [B_MASK_WIDTH];
    map_vec_t  cp_map [B_MASK_WIDTH];
    free_vec_t cp_free [B_MASK_WIDTH];

    b_mask_t   squash_mask;
    b_mask_t   freed_mask;
    addr_t     sel_fallthrough;

    // Completions during reset or on slots that are not live are dropped here
    assign resolved_mask = (complete_valid && !reset) ? (complete_slot & live_mask) : '0;
    assign restore_valid = (|resolved_mask) && complete_mispred;

    // The resolving slot is one-hot so OR picks its checkpoint
    always_comb begin
        sel_fallthrough  = '0;
        rob_tail_restore = '0;
        restore_map      = '0;
        restore_free     = '0;
        for (int i = 0; i < B_MASK_WIDTH; i++) begin
            if (resolved_mask[i]) begin
                sel_fallthrough  = sel_fallthrough | cp_fallthrough[i];
                rob_tail_restore = rob_tail_restore | cp_rob_tail[i];
                restore_map      = restore_map | cp_map[i];
                restore_free     = restore_free | cp_free[i];
            end
        end
    end

    assign pc_restore = complete_taken ? complete_target : sel_fallthrough;

    // Younger branches depend on the mispredicted one and die with it
    always_comb begin
        squash_mask = '0;
        for (int i = 0; i < B_MASK_WIDTH; i++) begin
            squash_mask[i] = restore_valid && (|(dep_mask[i] & resolved_mask));
        end
    end

    assign freed_mask     = resolved_mask | squash_mask;
    assign surviving_mask = live_mask & ~freed_mask;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < B_MASK_WIDTH; i++) begin
                dep_mask[i]       <= '0;
                cp_rob_tail[i]    <= '0;
                cp_fallthrough[i] <= '0;
                cp_map[i]         <= '0;
                cp_free[i]        <= '0;
            end
        end else begin
            for (int i = 0; i < B_MASK_WIDTH; i++) begin
                if (dispatch_fire && new_slot[i]) begin
                    // A resolving branch this cycle is not a dependency anymore
                    dep_mask[i]       <= surviving_mask;
                    cp_rob_tail[i]    <= dispatch_rob_tail;
                    cp_fallthrough[i] <= dispatch_fallthrough_pc;
                    cp_map[i]         <= map_snapshot;
                    cp_free[i]        <= free_snapshot;
                end else if (freed_mask[i]) begin
                    dep_mask[i] <= '0;
                end else begin
                    dep_mask[i] <= dep_mask[i] & ~resolved_mask;
                end
            end
        end
    end

endmodule

// File: rtl/dispatch_ctrl.sv
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic            clock,
    input  logic            reset,
    input  logic            dispatch_valid,
    input  logic            dispatch_branch,
    input  logic            dispatch_has_dest,
    input  logic            free_empty,
    input  logic            restore_valid,
    input  bs_pkg::b_mask_t surviving_mask,
    output bs_pkg::b_mask_t live_mask,
    output bs_pkg::b_mask_t new_slot,
    output logic            dispatch_stall,
    output logic            dispatch_fire
);

    import bs_pkg::*;

    b_mask_t free_slot;
    b_mask_t live_mask_next;
    logic    slots_full;
    logic    branch_stall;
    logic    dest_stall;

    // Lowest clear bit of the live mask, as a one-hot slot
    always_comb begin
        free_slot = '0;
        for (int i = B_MASK_WIDTH - 1; i >= 0; i--) begin
            if (!live_mask[i]) begin
                free_slot = b_mask_t'(1) << i;
            end
        end
    end

    assign slots_full = &live_mask;

    // A branch needs a slot and a renaming instruction needs a register
    assign branch_stall   = dispatch_branch && slots_full;
    assign dest_stall     = dispatch_has_dest && free_empty;
    assign dispatch_stall = dispatch_valid && (branch_stall || dest_stall);

    // Restore and reset both take priority over a dispatch in the same cycle
    assign dispatch_fire = dispatch_valid && !dispatch_stall && !restore_valid && !reset;

    assign new_slot = (dispatch_fire && dispatch_branch) ? free_slot : '0;

    // Resolved and squashed slots are already gone from surviving_mask
    assign live_mask_next = surviving_mask | new_slot;

    always_ff @(posedge clock) begin
        if (reset) begin
            live_mask <= '0;
        end else begin
            live_mask <= live_mask_next;
        end
    end

endmodule

// File: rtl/bs_pkg.sv
package bs_pkg;

    // Sizes of the recovery structures
    localparam int B_MASK_WIDTH   = 4;
    localparam int ARCH_REGS      = 8;
    localparam int PHYS_REGS      = 16;
    localparam int ARCH_IDX_WIDTH = 3;
    localparam int PHYS_IDX_WIDTH = 4;
    localparam int ROB_IDX_WIDTH  = 4;
    localparam int ADDR_WIDTH     = 32;

    typedef logic [B_MASK_WIDTH-1:0]             b_mask_t;
    typedef logic [ARCH_IDX_WIDTH-1:0]           arch_idx_t;
    typedef logic [PHYS_IDX_WIDTH-1:0]           phys_idx_t;
    typedef logic [PHYS_REGS-1:0]                free_vec_t;
    typedef logic [ARCH_REGS*PHYS_IDX_WIDTH-1:0] map_vec_t;
    typedef logic [ROB_IDX_WIDTH-1:0]            rob_idx_t;
    typedef logic [ADDR_WIDTH-1:0]               addr_t;

    // Arch i starts out on phys i
    function automatic map_vec_t identity_map();
        map_vec_t m;
        for (int i = 0; i < ARCH_REGS; i++) begin
            m[i*PHYS_IDX_WIDTH +: PHYS_IDX_WIDTH] = phys_idx_t'(i);
        end
        return m;
    endfunction

    // Everything above the architectural range is free
    function automatic free_vec_t upper_free();
        free_vec_t f;
        for (int i = 0; i < PHYS_REGS; i++) begin
            f[i] = (i >= ARCH_REGS);
        end
        return f;
    endfunction

    localparam map_vec_t  RESET_MAP  = identity_map();
    localparam free_vec_t RESET_FREE = upper_free();

endpackage
